// File: hdl/aes_inv_round.sv
`include "aes_defs.svh"

module aes_inv_round
(
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  aes_pkg::block_t cipher_block,
    input  aes_pkg::block_t round_key,
    output logic            out_valid,
    output aes_pkg::block_t plain_block
);

    localparam int num_rows = `AES_WORD_BITS / `AES_BYTE_BITS;

    aes_pkg::block_t key_added;
    aes_pkg::block_t mixed;
    aes_pkg::block_t stage1_q;
    aes_pkg::block_t shifted;
    aes_pkg::block_t subbed;

    // Bit 0 marks stage 1, top bit is the output stage
    logic [`AES_PIPE_DEPTH-1:0] valid_pipe;

    // ####################
    // Stage 1
    // ####################

    assign key_added = cipher_block ^ round_key;

    inv_mix_columns inv_mix_columns_i
    (
        .state_in  (key_added),
        .state_out (mixed)
    );

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            stage1_q <= mixed;
        end
    end

    // ####################
    // Stage 2
    // ####################

    // InvShiftRows is pure byte routing
    // Row r of column c comes from column (c - r) mod 4, row 0 stays put
    for (genvar c = 0; c < `AES_NUM_COLS; c++)
    begin : g_col
        for (genvar r = 0; r < num_rows; r++)
        begin : g_row
            localparam int src_col = (c - r + `AES_NUM_COLS) % `AES_NUM_COLS;
            localparam int dst_lsb = (`AES_NUM_COLS - 1 - c) * `AES_WORD_BITS
                                   + (num_rows - 1 - r) * `AES_BYTE_BITS;
            localparam int src_lsb = (`AES_NUM_COLS - 1 - src_col) * `AES_WORD_BITS
                                   + (num_rows - 1 - r) * `AES_BYTE_BITS;

            assign shifted[dst_lsb +: `AES_BYTE_BITS] =
                stage1_q[src_lsb +: `AES_BYTE_BITS];
        end
    end

    inv_sub_bytes inv_sub_bytes_i
    (
        .state_in  (shifted),
        .state_out (subbed)
    );

    // Output holds its last result between strobes
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            plain_block <= '0;
        end
        else if (valid_pipe[0])
        begin
            plain_block <= subbed;
        end
    end

    // ####################
    // Valid tracking
    // ####################

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_pipe <= '0;
        end
        else
        begin
            valid_pipe <= {valid_pipe[`AES_PIPE_DEPTH-2:0], in_valid};
        end
    end

    assign out_valid = valid_pipe[`AES_PIPE_DEPTH-1];

endmodule

// File: hdl/aes_pkg.sv
`include "aes_defs.svh"

package aes_pkg;

    // ####################
    // Data types
    // ####################

    // Full cipher state or round key
    // Column 0 sits in the top 32 bits, byte 0 of a column in its top 8 bits
    typedef logic [`AES_BLOCK_BITS-1:0] block_t;

    // One column of four bytes
    typedef logic [`AES_WORD_BITS-1:0] word_t;

    // GF(2^8) element
    typedef logic [`AES_BYTE_BITS-1:0] byte_t;

endpackage

// File: hdl/inv_mix_columns.sv
`include "aes_defs.svh"

module inv_mix_columns
(
    input  aes_pkg::block_t state_in,
    output aes_pkg::block_t state_out
);

    // ####################
    // GF(2^8) multipliers
    // ####################

    // Multiply by x, reducing when the top bit falls out
    function automatic aes_pkg::byte_t xtime(input aes_pkg::byte_t b);
        aes_pkg::byte_t shifted;
        shifted = {b[`AES_BYTE_BITS-2:0], 1'b0};
        return b[`AES_BYTE_BITS-1] ? (shifted ^ `AES_GF_POLY) : shifted;
    endfunction

    // 9 = 8 + 1
    function automatic aes_pkg::byte_t mul_9(input aes_pkg::byte_t b);
        aes_pkg::byte_t x8;
        x8 = xtime(xtime(xtime(b)));
        return x8 ^ b;
    endfunction

    // 11 = 8 + 2 + 1
    function automatic aes_pkg::byte_t mul_11(input aes_pkg::byte_t b);
        aes_pkg::byte_t x2;
        aes_pkg::byte_t x8;
        x2 = xtime(b);
        x8 = xtime(xtime(x2));
        return x8 ^ x2 ^ b;
    endfunction

    // 13 = 8 + 4 + 1
    function automatic aes_pkg::byte_t mul_13(input aes_pkg::byte_t b);
        aes_pkg::byte_t x4;
        aes_pkg::byte_t x8;
        x4 = xtime(xtime(b));
        x8 = xtime(x4);
        return x8 ^ x4 ^ b;
    endfunction

    // 14 = 8 + 4 + 2
    function automatic aes_pkg::byte_t mul_14(input aes_pkg::byte_t b);
        aes_pkg::byte_t x2;
        aes_pkg::byte_t x4;
        aes_pkg::byte_t x8;
        x2 = xtime(b);
        x4 = xtime(x2);
        x8 = xtime(x4);
        return x8 ^ x4 ^ x2;
    endfunction

    // ####################
    // Column mix
    // ####################

    // Matrix rows are 14 11 13 9, each rotated right by one from the last
    function automatic aes_pkg::word_t inv_mix_col(input aes_pkg::word_t col);
        aes_pkg::byte_t b0;
        aes_pkg::byte_t b1;
        aes_pkg::byte_t b2;
        aes_pkg::byte_t b3;
        aes_pkg::byte_t m0;
        aes_pkg::byte_t m1;
        aes_pkg::byte_t m2;
        aes_pkg::byte_t m3;
        {b0, b1, b2, b3} = col;
        m0 = mul_14(b0) ^ mul_11(b1) ^ mul_13(b2) ^ mul_9(b3);
        m1 = mul_9(b0) ^ mul_14(b1) ^ mul_11(b2) ^ mul_13(b3);
        m2 = mul_13(b0) ^ mul_9(b1) ^ mul_14(b2) ^ mul_11(b3);
        m3 = mul_11(b0) ^ mul_13(b1) ^ mul_9(b2) ^ mul_14(b3);
        return {m0, m1, m2, m3};
    endfunction

    // Column 0 occupies the top word
    for (genvar c = 0; c < `AES_NUM_COLS; c++)
    begin : g_col
        localparam int lsb = (`AES_NUM_COLS - 1 - c) * `AES_WORD_BITS;

        assign state_out[lsb +: `AES_WORD_BITS] =
            inv_mix_col(state_in[lsb +: `AES_WORD_BITS]);
    end

endmodule

// File: hdl/inv_sub_bytes.sv
`include "aes_defs.svh"

module inv_sub_bytes
(
    input  aes_pkg::block_t state_in,
    output aes_pkg::block_t state_out
);

    localparam int num_bytes = `AES_BLOCK_BITS / `AES_BYTE_BITS;

    // ####################
    // Inverse S-box
    // ####################

    // Entry 0 is the leftmost byte, one row of sixteen per line
    localparam aes_pkg::byte_t [0:255] inv_sbox =
    {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    // ####################
    // Byte substitution
    // ####################

    // Each byte looks up its own copy of the table
    for (genvar i = 0; i < num_bytes; i++)
    begin : g_byte
        assign state_out[i*`AES_BYTE_BITS +: `AES_BYTE_BITS] =
            inv_sbox[state_in[i*`AES_BYTE_BITS +: `AES_BYTE_BITS]];
    end

endmodule

// File: include/aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// ####################
// Block geometry
// ####################

// One state or one round key
`define AES_BLOCK_BITS 128
// One column of the state
`define AES_WORD_BITS 32
`define AES_BYTE_BITS 8
`define AES_NUM_COLS 4

// ####################
// Arithmetic and timing
// ####################

// x^8 = x^4 + x^3 + x + 1 folded back into the low byte
`define AES_GF_POLY 8'h1b
// Cycles from in_valid to out_valid
`define AES_PIPE_DEPTH 2

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AES inverse round testbench with Verilator

set -u

cd "$(dirname "$0")"

log_file="sim.log"
top="aes_inv_round_tb"
exe="${top}_sim"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module "${top}" \
    --Mdir obj_dir \
    -o "${exe}"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"${exe}" 2>&1 | tee "${log_file}"
run_status=${PIPESTATUS[0]}
if [ "${run_status}" -ne 0 ]; then
    echo "Simulation exited with status ${run_status}"
    exit 1
fi

if grep -q "SIMULATION FAILED" "${log_file}"; then
    exit 1
fi

exit 0

// File: verification/aes_inv_round_tb.sv
`include "aes_defs.svh"

module aes_inv_round_tb;

    localparam int clk_period = 100;
    localparam int drive_delay = 10;
    localparam int drain_timeout = 20;
    localparam int num_bytes = `AES_BLOCK_BITS / `AES_BYTE_BITS;

    logic            clk;
    logic            rst;
    logic            in_valid;
    aes_pkg::block_t cipher_block;
    aes_pkg::block_t round_key;
    logic            out_valid;
    aes_pkg::block_t plain_block;

    logic [31:0]     lfsr;
    aes_pkg::byte_t  inv_sbox_model [256];
    aes_pkg::block_t exp_q [$];
    int              tag_q [$];
    aes_pkg::block_t last_result;
    int              cycle;
    bit              checking;
    int              errors;
    int              tests_run;
    int              tests_failed;

    aes_inv_round aes_inv_round_i
    (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .cipher_block (cipher_block),
        .round_key    (round_key),
        .out_valid    (out_valid),
        .plain_block  (plain_block)
    );

    // ####################
    // Clock and cycle count
    // ####################

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        cycle = 0;
        forever
        begin
            @(posedge clk);
            cycle++;
        end
    end

    // ####################
    // Random source
    // ####################

    // Galois LFSR stepped once per bit
    function automatic aes_pkg::block_t take_bits(input int n);
        aes_pkg::block_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[`AES_BLOCK_BITS-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // ####################
    // Reference model
    // ####################

    function automatic aes_pkg::byte_t gf_mul(input aes_pkg::byte_t a, input aes_pkg::byte_t b);
        aes_pkg::byte_t p;
        aes_pkg::byte_t aa;
        aes_pkg::byte_t bb;
        p = '0;
        aa = a;
        bb = b;
        for (int i = 0; i < 8; i++)
        begin
            if (bb[0])
                p = p ^ aa;
            aa = aa[7] ? ((aa << 1) ^ `AES_GF_POLY) : (aa << 1);
            bb = bb >> 1;
        end
        return p;
    endfunction

    function automatic aes_pkg::byte_t rotl(input aes_pkg::byte_t v, input int n);
        return (v << n) | (v >> (8 - n));
    endfunction

    // Undo the S-box affine map, then invert in GF(2^8) by search
    function automatic aes_pkg::byte_t inv_sbox_entry(input aes_pkg::byte_t y);
        aes_pkg::byte_t a;
        aes_pkg::byte_t result;
        a = rotl(y, 1) ^ rotl(y, 3) ^ rotl(y, 6) ^ 8'h05;
        result = '0;
        for (int x = 1; x < 256; x++)
        begin
            if (gf_mul(a, x[7:0]) == 8'h01)
                result = x[7:0];
        end
        return result;
    endfunction

    // Byte k is row k%4 of column k/4, byte 0 at the top
    function automatic aes_pkg::byte_t get_byte(input aes_pkg::block_t blk, input int k);
        return blk[`AES_BLOCK_BITS-1-8*k -: 8];
    endfunction

    function automatic aes_pkg::byte_t mix_coef(input int d);
        case (d)
            0: return 8'h0e;
            1: return 8'h0b;
            2: return 8'h0d;
            default: return 8'h09;
        endcase
    endfunction

    function automatic aes_pkg::block_t unmix_columns(input aes_pkg::block_t blk);
        aes_pkg::block_t res;
        aes_pkg::byte_t acc;
        res = '0;
        for (int c = 0; c < 4; c++)
        begin
            for (int i = 0; i < 4; i++)
            begin
                acc = '0;
                for (int j = 0; j < 4; j++)
                    acc = acc ^ gf_mul(mix_coef((j - i + 4) % 4), get_byte(blk, 4*c + j));
                res[`AES_BLOCK_BITS-1-8*(4*c + i) -: 8] = acc;
            end
        end
        return res;
    endfunction

    function automatic aes_pkg::block_t shift_rows_back(input aes_pkg::block_t blk);
        aes_pkg::block_t res;
        res = '0;
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                res[`AES_BLOCK_BITS-1-8*(4*c + r) -: 8] = get_byte(blk, 4*((c - r + 4) % 4) + r);
        return res;
    endfunction

    function automatic aes_pkg::block_t substitute_bytes(input aes_pkg::block_t blk);
        aes_pkg::block_t res;
        res = '0;
        for (int k = 0; k < num_bytes; k++)
            res[`AES_BLOCK_BITS-1-8*k -: 8] = inv_sbox_model[get_byte(blk, k)];
        return res;
    endfunction

    function automatic aes_pkg::block_t expected_round(input aes_pkg::block_t blk,
                                                       input aes_pkg::block_t key);
        return substitute_bytes(shift_rows_back(unmix_columns(blk ^ key)));
    endfunction

    // ####################
    // Scoreboard
    // ####################

    task automatic check_outputs();
        logic exp_valid;
        exp_valid = (tag_q.size() > 0) && (tag_q[0] + `AES_PIPE_DEPTH == cycle);
        assert (out_valid === exp_valid)
        else
        begin
            $display("[ERROR] t=%0t out_valid exp=%0b got=%0b", $time, exp_valid, out_valid);
            errors++;
        end
        if (exp_valid)
        begin
            tag_q.delete(0);
            last_result = exp_q.pop_front();
        end
        assert (plain_block === last_result)
        else
        begin
            $display("[ERROR] t=%0t plain_block exp=%h got=%h", $time, last_result, plain_block);
            errors++;
        end
    endtask

    initial
    begin
        forever
        begin
            @(negedge clk);
            if (checking)
                check_outputs();
        end
    end

    // ####################
    // Stimulus tasks
    // ####################

    task automatic issue_cycle(input logic v, input aes_pkg::block_t blk,
                               input aes_pkg::block_t key);
        @(posedge clk);
        #(drive_delay);
        in_valid = v;
        cipher_block = blk;
        round_key = key;
        if (v)
        begin
            exp_q.push_back(expected_round(blk, key));
            tag_q.push_back(cycle);
        end
    endtask

    // Idle cycles carry random data that must not disturb the output
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < drain_timeout)
        begin
            issue_cycle(1'b0, take_bits(128), take_bits(128));
            waited++;
        end
        if (exp_q.size() > 0)
        begin
            $display("Timed out waiting for out_valid with %0d blocks pending", exp_q.size());
            errors++;
            exp_q.delete();
            tag_q.delete();
        end
        issue_cycle(1'b0, take_bits(128), take_bits(128));
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
        begin
            $display("Test %0d %s: ok", tests_run, name);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_before);
        end
    endtask

    // ####################
    // Test sequence
    // ####################

    initial
    begin
        int errors_before;
        aes_pkg::block_t bit_pick;

        rst = 1'b1;
        in_valid = 1'b0;
        cipher_block = '0;
        round_key = '0;
        lfsr = 32'h9db280f3;
        last_result = '0;
        checking = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;

        for (int y = 0; y < 256; y++)
            inv_sbox_model[y] = inv_sbox_entry(y[7:0]);

        repeat (5) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;
        checking = 1'b1;

        errors_before = errors;
        for (int i = 0; i < 6; i++)
            issue_cycle(1'b0, take_bits(128), take_bits(128));
        report_test("idle after reset", errors_before);

        errors_before = errors;
        for (int i = 0; i < 4; i++)
        begin
            issue_cycle(1'b1, take_bits(128), '0);
            drain();
        end
        report_test("single block, zero key", errors_before);

        errors_before = errors;
        for (int i = 0; i < 20; i++)
        begin
            issue_cycle(1'b1, take_bits(128), take_bits(128));
            drain();
        end
        report_test("random blocks and keys", errors_before);

        errors_before = errors;
        for (int i = 0; i < 8; i++)
            issue_cycle(1'b1, take_bits(128), take_bits(128));
        drain();
        report_test("back-to-back burst", errors_before);

        errors_before = errors;
        for (int i = 0; i < 40; i++)
        begin
            bit_pick = take_bits(1);
            issue_cycle(bit_pick[0], take_bits(128), take_bits(128));
        end
        drain();
        report_test("random valid gaps", errors_before);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hdl/aes_pkg.sv
hdl/inv_sub_bytes.sv
hdl/inv_mix_columns.sv
hdl/aes_inv_round.sv
verification/aes_inv_round_tb.sv
